// File: include/phy_defs.svh
`ifndef PHY_DEFS_SVH
`define PHY_DEFS_SVH

// Bit positions inside the PHY configuration word

// Read latency field occupies [LSB+3:LSB]
`define PHY_CFG_RDLAT_LSB 8

`endif

// File: hw/ddr3_pins_pkg.sv
`default_nettype none

// DDR3 device side of the PHY
package ddr3_pins_pkg;

    //------------------------------------------------------------
    // Pin group widths
    //------------------------------------------------------------

    // x16 part
    localparam int DQ_W   = 16;
    localparam int DM_W   = 2;

    // Bank and row/column address
    localparam int BA_W   = 3;
    localparam int ADDR_W = 15;

    //------------------------------------------------------------
    // Edge halves
    //------------------------------------------------------------

    // Value driven or captured on one clock edge of the DQ lines
    typedef logic [DQ_W-1:0] dq_half_t;

    // Same for the data mask lines
    typedef logic [DM_W-1:0] dm_half_t;

endpackage

`default_nettype wire

// File: hw/dfi_pkg.sv
`default_nettype none

// DFI controller side of the PHY
package dfi_pkg;

`include "phy_defs.svh"

    //------------------------------------------------------------
    // Word widths
    //------------------------------------------------------------

    // One DFI word carries both edges of a DDR transfer
    localparam int DFI_DATA_W = 2 * ddr3_pins_pkg::DQ_W;
    localparam int DFI_MASK_W = 2 * ddr3_pins_pkg::DM_W;

    // Configuration word
    localparam int PHY_CFG_W  = 32;
    localparam int RD_LAT_W   = 4;

    typedef logic [RD_LAT_W-1:0] rd_lat_t;

    //------------------------------------------------------------
    // Configuration word views
    //------------------------------------------------------------

    // Field view, MSB first
    typedef struct packed {
        logic [PHY_CFG_W-1:`PHY_CFG_RDLAT_LSB+RD_LAT_W] rsvd_hi;
        rd_lat_t                                        rd_lat;
        logic [`PHY_CFG_RDLAT_LSB-1:0]                  rsvd_lo;
    } phy_cfg_fields_t;

    // Raw word as written by software, or its decoded fields
    typedef union packed {
        logic [PHY_CFG_W-1:0] raw;
        phy_cfg_fields_t      field;
    } phy_cfg_u;

endpackage

`default_nettype wire

// File: hw/ddr3_cmd_out.sv
`timescale 1ns/1ps
`default_nettype none

// Output register stage for the DDR3 command and address pins
module ddr3_cmd_out
(
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,

    // DFI command
    input  wire logic                             dfi_cke_i,
    input  wire logic                             dfi_reset_n_i,
    input  wire logic                             dfi_cs_n_i,
    input  wire logic                             dfi_ras_n_i,
    input  wire logic                             dfi_cas_n_i,
    input  wire logic                             dfi_we_n_i,
    input  wire logic                             dfi_odt_i,
    input  wire logic [ddr3_pins_pkg::BA_W-1:0]   dfi_bank_i,
    input  wire logic [ddr3_pins_pkg::ADDR_W-1:0] dfi_address_i,

    // DDR3 command pins
    output logic                                  ddr3_cke_o,
    output logic                                  ddr3_reset_n_o,
    output logic                                  ddr3_cs_n_o,
    output logic                                  ddr3_ras_n_o,
    output logic                                  ddr3_cas_n_o,
    output logic                                  ddr3_we_n_o,
    output logic                                  ddr3_odt_o,
    output logic [ddr3_pins_pkg::BA_W-1:0]        ddr3_ba_o,
    output logic [ddr3_pins_pkg::ADDR_W-1:0]      ddr3_addr_o
);

    // Whole group registered on one edge so it leaves the chip aligned.
    // Reset holds every pin low, including the active-low strobes
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ddr3_cke_o     <= 1'b0;
            ddr3_reset_n_o <= 1'b0;
            ddr3_cs_n_o    <= 1'b0;
            ddr3_ras_n_o   <= 1'b0;
            ddr3_cas_n_o   <= 1'b0;
            ddr3_we_n_o    <= 1'b0;
            ddr3_odt_o     <= 1'b0;
            ddr3_ba_o      <= '0;
            ddr3_addr_o    <= '0;
        end
        else
        begin
            ddr3_cke_o     <= dfi_cke_i;
            ddr3_reset_n_o <= dfi_reset_n_i;
            ddr3_cs_n_o    <= dfi_cs_n_i;
            ddr3_ras_n_o   <= dfi_ras_n_i;
            ddr3_cas_n_o   <= dfi_cas_n_i;
            ddr3_we_n_o    <= dfi_we_n_i;
            ddr3_odt_o     <= dfi_odt_i;
            ddr3_ba_o      <= dfi_bank_i;
            ddr3_addr_o    <= dfi_address_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/ddr3_wr_path.sv
`timescale 1ns/1ps
`default_nettype none

// Write data path and shared DQ/DM/DQS output enable
module ddr3_wr_path
(
    input  wire logic                            clk_i,
    input  wire logic                            rst_i,

    // DFI write side
    input  wire logic [dfi_pkg::DFI_DATA_W-1:0]  dfi_wrdata_i,
    input  wire logic [dfi_pkg::DFI_MASK_W-1:0]  dfi_wrdata_mask_i,
    input  wire logic                            dfi_wrdata_en_i,

    // Edge halves towards the output DDR registers
    output ddr3_pins_pkg::dq_half_t              dq_rise_o,
    output ddr3_pins_pkg::dq_half_t              dq_fall_o,
    output ddr3_pins_pkg::dm_half_t              dm_rise_o,
    output ddr3_pins_pkg::dm_half_t              dm_fall_o,
    output logic                                 dq_oe_o
);

    import ddr3_pins_pkg::*;
    import dfi_pkg::*;

    logic [DFI_DATA_W-1:0] wrdata_q;
    logic [DFI_MASK_W-1:0] wrmask_q;

    // Enable history, bit 0 is the newest sample
    logic [2:0]            wr_en_q;
    logic                  oe_q;

    //------------------------------------------------------------
    // Write data and mask
    //------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wrdata_q <= '0;
            wrmask_q <= '0;
        end
        else
        begin
            wrdata_q <= dfi_wrdata_i;
            wrmask_q <= dfi_wrdata_mask_i;
        end
    end

    // Low half goes out on the rising edge, high half on the falling edge
    assign dq_rise_o = wrdata_q[DQ_W-1:0];
    assign dq_fall_o = wrdata_q[DFI_DATA_W-1:DQ_W];
    assign dm_rise_o = wrmask_q[DM_W-1:0];
    assign dm_fall_o = wrmask_q[DFI_MASK_W-1:DM_W];

    //------------------------------------------------------------
    // Output enable
    //------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_en_q <= '0;
        end
        else
        begin
            wr_en_q <= {wr_en_q[1:0], dfi_wrdata_en_i};
        end
    end

    // Turn on from stage 1 (preamble), hold while stage 2 is still set.
    // Stage 2 lagging one more cycle gives the postamble
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            oe_q <= 1'b0;
        end
        else if (wr_en_q[1])
        begin
            oe_q <= 1'b1;
        end
        else if (!wr_en_q[2])
        begin
            oe_q <= 1'b0;
        end
    end

    assign dq_oe_o = oe_q;

endmodule

`default_nettype wire

// File: hw/ddr3_rd_path.sv
`timescale 1ns/1ps
`default_nettype none

// Read data reassembly and read-valid timing
module ddr3_rd_path
#(
    parameter int unsigned TPHY_RDLAT = 4,
    parameter int unsigned RD_SHIFT_W = 12
)
(
    input  wire logic                            clk_i,
    input  wire logic                            rst_i,

    // Configuration write
    input  wire logic                            cfg_valid_i,
    input  wire dfi_pkg::phy_cfg_u               cfg_i,

    // Captured halves from the input DDR registers
    input  wire ddr3_pins_pkg::dq_half_t         dq_rise_i,
    input  wire ddr3_pins_pkg::dq_half_t         dq_fall_i,

    // DFI read side
    input  wire logic                            dfi_rddata_en_i,
    output logic [dfi_pkg::DFI_DATA_W-1:0]       dfi_rddata_o,
    output logic                                 dfi_rddata_valid_o
);

    import dfi_pkg::*;

    rd_lat_t               rd_lat_q;
    logic [RD_SHIFT_W-1:0] rd_en_q;
    logic [RD_SHIFT_W-1:0] rd_en_next;

    //------------------------------------------------------------
    // Read latency register
    //------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_lat_q <= rd_lat_t'(TPHY_RDLAT);
        end
        else if (cfg_valid_i)
        begin
            rd_lat_q <= cfg_i.field.rd_lat;
        end
    end

    //------------------------------------------------------------
    // Read data
    //------------------------------------------------------------

    // Rising-edge capture is the low half of the DFI word
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dfi_rddata_o <= '0;
        end
        else
        begin
            dfi_rddata_o <= {dq_fall_i, dq_rise_i};
        end
    end

    //------------------------------------------------------------
    // Read valid
    //------------------------------------------------------------

    // Shift toward bit 0 and drop the new enable in at the latency slot.
    // Several reads may be in flight at once
    always_comb
    begin
        rd_en_next = {1'b0, rd_en_q[RD_SHIFT_W-1:1]};
        if (int'(rd_lat_q) < int'(RD_SHIFT_W))
        begin
            rd_en_next[rd_lat_q] = dfi_rddata_en_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_en_q <= '0;
        end
        else
        begin
            rd_en_q <= rd_en_next;
        end
    end

    assign dfi_rddata_valid_o = rd_en_q[0];

endmodule

`default_nettype wire

// File: hw/ddr3_dfi_phy.sv
`timescale 1ns/1ps
`default_nettype none

// DDR3 DFI PHY logic core, pads and DDR cells live in the board wrapper
module ddr3_dfi_phy
#(
    parameter int unsigned TPHY_RDLAT = 4,
    parameter int unsigned RD_SHIFT_W = 12
)
(
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,

    // Configuration
    input  wire logic                             cfg_valid_i,
    input  wire logic [dfi_pkg::PHY_CFG_W-1:0]    cfg_i,

    // DFI command
    input  wire logic                             dfi_cke_i,
    input  wire logic                             dfi_reset_n_i,
    input  wire logic                             dfi_cs_n_i,
    input  wire logic                             dfi_ras_n_i,
    input  wire logic                             dfi_cas_n_i,
    input  wire logic                             dfi_we_n_i,
    input  wire logic                             dfi_odt_i,
    input  wire logic [ddr3_pins_pkg::BA_W-1:0]   dfi_bank_i,
    input  wire logic [ddr3_pins_pkg::ADDR_W-1:0] dfi_address_i,

    // DFI write
    input  wire logic [dfi_pkg::DFI_DATA_W-1:0]   dfi_wrdata_i,
    input  wire logic [dfi_pkg::DFI_MASK_W-1:0]   dfi_wrdata_mask_i,
    input  wire logic                             dfi_wrdata_en_i,

    // DFI read
    input  wire logic                             dfi_rddata_en_i,
    output logic [dfi_pkg::DFI_DATA_W-1:0]        dfi_rddata_o,
    output logic                                  dfi_rddata_valid_o,

    // DDR3 command pins
    output logic                                  ddr3_cke_o,
    output logic                                  ddr3_reset_n_o,
    output logic                                  ddr3_cs_n_o,
    output logic                                  ddr3_ras_n_o,
    output logic                                  ddr3_cas_n_o,
    output logic                                  ddr3_we_n_o,
    output logic                                  ddr3_odt_o,
    output logic [ddr3_pins_pkg::BA_W-1:0]        ddr3_ba_o,
    output logic [ddr3_pins_pkg::ADDR_W-1:0]      ddr3_addr_o,

    // DQ/DM output halves and shared enable
    output logic [ddr3_pins_pkg::DQ_W-1:0]        dq_rise_o,
    output logic [ddr3_pins_pkg::DQ_W-1:0]        dq_fall_o,
    output logic [ddr3_pins_pkg::DM_W-1:0]        dm_rise_o,
    output logic [ddr3_pins_pkg::DM_W-1:0]        dm_fall_o,
    output logic                                  dq_oe_o,

    // DQ input halves
    input  wire logic [ddr3_pins_pkg::DQ_W-1:0]   dq_rise_i,
    input  wire logic [ddr3_pins_pkg::DQ_W-1:0]   dq_fall_i
);

    //------------------------------------------------------------
    // Command
    //------------------------------------------------------------
    ddr3_cmd_out u_cmd
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .dfi_cke_i      (dfi_cke_i),
        .dfi_reset_n_i  (dfi_reset_n_i),
        .dfi_cs_n_i     (dfi_cs_n_i),
        .dfi_ras_n_i    (dfi_ras_n_i),
        .dfi_cas_n_i    (dfi_cas_n_i),
        .dfi_we_n_i     (dfi_we_n_i),
        .dfi_odt_i      (dfi_odt_i),
        .dfi_bank_i     (dfi_bank_i),
        .dfi_address_i  (dfi_address_i),
        .ddr3_cke_o     (ddr3_cke_o),
        .ddr3_reset_n_o (ddr3_reset_n_o),
        .ddr3_cs_n_o    (ddr3_cs_n_o),
        .ddr3_ras_n_o   (ddr3_ras_n_o),
        .ddr3_cas_n_o   (ddr3_cas_n_o),
        .ddr3_we_n_o    (ddr3_we_n_o),
        .ddr3_odt_o     (ddr3_odt_o),
        .ddr3_ba_o      (ddr3_ba_o),
        .ddr3_addr_o    (ddr3_addr_o)
    );

    //------------------------------------------------------------
    // Write
    //------------------------------------------------------------
    ddr3_wr_path u_wr
    (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .dfi_wrdata_i      (dfi_wrdata_i),
        .dfi_wrdata_mask_i (dfi_wrdata_mask_i),
        .dfi_wrdata_en_i   (dfi_wrdata_en_i),
        .dq_rise_o         (dq_rise_o),
        .dq_fall_o         (dq_fall_o),
        .dm_rise_o         (dm_rise_o),
        .dm_fall_o         (dm_fall_o),
        .dq_oe_o           (dq_oe_o)
    );

    //------------------------------------------------------------
    // Read
    //------------------------------------------------------------
    ddr3_rd_path
    #(
        .TPHY_RDLAT (TPHY_RDLAT),
        .RD_SHIFT_W (RD_SHIFT_W)
    )
    u_rd
    (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cfg_valid_i        (cfg_valid_i),
        .cfg_i              (cfg_i),
        .dq_rise_i          (dq_rise_i),
        .dq_fall_i          (dq_fall_i),
        .dfi_rddata_en_i    (dfi_rddata_en_i),
        .dfi_rddata_o       (dfi_rddata_o),
        .dfi_rddata_valid_o (dfi_rddata_valid_o)
    );

endmodule

`default_nettype wire

// File: test/tb_ddr3_checks.svh
`ifndef TB_DDR3_CHECKS_SVH
`define TB_DDR3_CHECKS_SVH

//------------------------------------------------------------
// Expected values from the input history
//------------------------------------------------------------

// Command group leaves one cycle after it was presented
function automatic cmd_t delayed_cmd(int k);
    return cmd_h[k-1];
endfunction

function automatic logic [DFI_DATA_W-1:0] delayed_wrdata(int k);
    return wrdata_h[k-1];
endfunction

function automatic logic [DFI_MASK_W-1:0] delayed_wrmask(int k);
    return wrmask_h[k-1];
endfunction

// Enable seen 3 or 4 cycles back, the older one is the postamble
function automatic logic oe_from_history(int k);
    logic older;
    // Nothing was enabled before the first recorded cycle
    older = (k >= 5) ? wr_en_h[k-4] : 1'b0;
    return wr_en_h[k-3] | older;
endfunction

// Fall half on top, rise half below
function automatic logic [DFI_DATA_W-1:0] rddata_from_halves(int k);
    return {fall_h[k-1], rise_h[k-1]};
endfunction

// Any read enable whose own latency lands on cycle k
function automatic logic valid_from_history(int k);
    logic hit;
    hit = 1'b0;
    for (int j = k - 1; j >= 0 && j >= k - 20; j--)
    begin
        if (rd_en_h[j] && (j + int'(lat_h[j]) + 1 == k))
        begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

//------------------------------------------------------------
// Compare tasks
//------------------------------------------------------------

task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    stop_on_error($sformatf("CHECK FAILED time %0t: %s expected 0x%0h actual 0x%0h",
                            $time, name, exp, act));
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic check_dq_half(string name, dq_half_t exp, dq_half_t act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic check_dm_half(string name, dm_half_t exp, dm_half_t act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic check_word(string name, logic [DFI_DATA_W-1:0] exp,
                          logic [DFI_DATA_W-1:0] act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic check_bank(string name, logic [BA_W-1:0] exp, logic [BA_W-1:0] act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic check_addr(string name, logic [ADDR_W-1:0] exp, logic [ADDR_W-1:0] act);
    if (act !== exp)
    begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

// Whole command pin group against one expected command
task automatic check_command(cmd_t exp);
    check_bit("ddr3_cke_o", exp.cke, ddr3_cke_o);
    check_bit("ddr3_reset_n_o", exp.reset_n, ddr3_reset_n_o);
    check_bit("ddr3_cs_n_o", exp.cs_n, ddr3_cs_n_o);
    check_bit("ddr3_ras_n_o", exp.ras_n, ddr3_ras_n_o);
    check_bit("ddr3_cas_n_o", exp.cas_n, ddr3_cas_n_o);
    check_bit("ddr3_we_n_o", exp.we_n, ddr3_we_n_o);
    check_bit("ddr3_odt_o", exp.odt, ddr3_odt_o);
    check_bank("ddr3_ba_o", exp.ba, ddr3_ba_o);
    check_addr("ddr3_addr_o", exp.addr, ddr3_addr_o);
endtask

`endif

// File: test/tb_ddr3_dfi_phy.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_defs.svh"

module tb_ddr3_dfi_phy;

    import ddr3_pins_pkg::*;
    import dfi_pkg::*;

    // Read latency the DUT comes out of reset with
    localparam int RESET_RD_LAT    = 4;

    localparam int N_RESET         = 3;
    localparam int N_RAND          = 150;
    localparam int N_DRAIN         = 16;
    localparam int TOTAL_CYCLES    = N_RESET + 3 * (N_RAND + N_DRAIN) + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 20;
    localparam int MAX_CYC         = WATCHDOG_CYCLES + 8;

    typedef struct packed {
        logic              cke;
        logic              reset_n;
        logic              cs_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic              odt;
        logic [BA_W-1:0]   ba;
        logic [ADDR_W-1:0] addr;
    } cmd_t;

    // DUT inputs
    logic                  clk_i;
    logic                  rst_i;
    logic                  cfg_valid_i;
    logic [PHY_CFG_W-1:0]  cfg_i;
    logic                  dfi_cke_i;
    logic                  dfi_reset_n_i;
    logic                  dfi_cs_n_i;
    logic                  dfi_ras_n_i;
    logic                  dfi_cas_n_i;
    logic                  dfi_we_n_i;
    logic                  dfi_odt_i;
    logic [BA_W-1:0]       dfi_bank_i;
    logic [ADDR_W-1:0]     dfi_address_i;
    logic [DFI_DATA_W-1:0] dfi_wrdata_i;
    logic [DFI_MASK_W-1:0] dfi_wrdata_mask_i;
    logic                  dfi_wrdata_en_i;
    logic                  dfi_rddata_en_i;
    dq_half_t              dq_rise_i;
    dq_half_t              dq_fall_i;

    // DUT outputs
    logic [DFI_DATA_W-1:0] dfi_rddata_o;
    logic                  dfi_rddata_valid_o;
    logic                  ddr3_cke_o;
    logic                  ddr3_reset_n_o;
    logic                  ddr3_cs_n_o;
    logic                  ddr3_ras_n_o;
    logic                  ddr3_cas_n_o;
    logic                  ddr3_we_n_o;
    logic                  ddr3_odt_o;
    logic [BA_W-1:0]       ddr3_ba_o;
    logic [ADDR_W-1:0]     ddr3_addr_o;
    dq_half_t              dq_rise_o;
    dq_half_t              dq_fall_o;
    dm_half_t              dm_rise_o;
    dm_half_t              dm_fall_o;
    logic                  dq_oe_o;

    integer                seed;
    int                    wr_left;
    logic                  wr_on;
    int                    cyc;
    rd_lat_t               model_lat;

    // Inputs as present in each cycle
    cmd_t                  cmd_h    [MAX_CYC];
    logic [DFI_DATA_W-1:0] wrdata_h [MAX_CYC];
    logic [DFI_MASK_W-1:0] wrmask_h [MAX_CYC];
    logic                  wr_en_h  [MAX_CYC];
    logic                  rd_en_h  [MAX_CYC];
    dq_half_t              rise_h   [MAX_CYC];
    dq_half_t              fall_h   [MAX_CYC];
    rd_lat_t               lat_h    [MAX_CYC];

    ddr3_dfi_phy u_dut (.*);

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

`include "tb_ddr3_checks.svh"

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #4 clk_i = ~clk_i;
        end
    end

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------

    // One cycle of random traffic, read enables only when allowed
    task automatic drive_cycle(logic rd_allow, logic cfg_wr, rd_lat_t lat);
        logic [31:0] r;
        logic [31:0] cfg;
        @(posedge clk_i);
        r = $random(seed);
        dfi_cke_i         <= r[0];
        dfi_reset_n_i     <= r[1];
        dfi_cs_n_i        <= r[2];
        dfi_ras_n_i       <= r[3];
        dfi_cas_n_i       <= r[4];
        dfi_we_n_i        <= r[5];
        dfi_odt_i         <= r[6];
        dfi_bank_i        <= r[9:7];
        dfi_address_i     <= r[24:10];
        dfi_rddata_en_i   <= rd_allow & r[25];
        dfi_wrdata_i      <= $random(seed);
        r = $random(seed);
        dfi_wrdata_mask_i <= r[3:0];
        dq_rise_i         <= r[31:16];
        r = $random(seed);
        dq_fall_i         <= r[15:0];
        // Alternating on/off runs of 1 to 6 beats
        if (wr_left == 0)
        begin
            wr_left = 1 + int'($unsigned($random(seed)) % 6);
            wr_on   = !wr_on;
        end
        wr_left = wr_left - 1;
        dfi_wrdata_en_i   <= wr_on;
        // Reserved bits stay random
        cfg = $random(seed);
        cfg[`PHY_CFG_RDLAT_LSB +: RD_LAT_W] = lat;
        cfg_i             <= cfg;
        cfg_valid_i       <= cfg_wr;
    endtask

    initial
    begin
        seed              = 32'hefe13f82;
        wr_left           = 0;
        wr_on             = 1'b0;
        rst_i             = 1'b1;
        cfg_valid_i       = 1'b0;
        cfg_i             = '0;
        dfi_cke_i         = 1'b0;
        dfi_reset_n_i     = 1'b0;
        dfi_cs_n_i        = 1'b0;
        dfi_ras_n_i       = 1'b0;
        dfi_cas_n_i       = 1'b0;
        dfi_we_n_i        = 1'b0;
        dfi_odt_i         = 1'b0;
        dfi_bank_i        = '0;
        dfi_address_i     = '0;
        dfi_wrdata_i      = '0;
        dfi_wrdata_mask_i = '0;
        dfi_wrdata_en_i   = 1'b0;
        dfi_rddata_en_i   = 1'b0;
        dq_rise_i         = '0;
        dq_fall_i         = '0;

        repeat (N_RESET) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_command('0);
        check_bit("dq_oe_o", 1'b0, dq_oe_o);
        check_bit("dfi_rddata_valid_o", 1'b0, dfi_rddata_valid_o);

        // Reset latency, then 0, then 7, draining reads before each change
        repeat (N_RAND) drive_cycle(1'b1, 1'b0, '0);
        repeat (N_DRAIN) drive_cycle(1'b0, 1'b0, '0);
        drive_cycle(1'b0, 1'b1, 4'd0);
        repeat (N_RAND) drive_cycle(1'b1, 1'b0, '0);
        repeat (N_DRAIN) drive_cycle(1'b0, 1'b0, '0);
        drive_cycle(1'b0, 1'b1, 4'd7);
        repeat (N_RAND) drive_cycle(1'b1, 1'b0, '0);
        repeat (N_DRAIN) drive_cycle(1'b0, 1'b0, '0);

        $display("sim passed");
        $finish;
    end

    //------------------------------------------------------------
    // Compare
    //------------------------------------------------------------

    task automatic record_inputs(int k);
        cmd_t cur;
        cur.cke     = dfi_cke_i;
        cur.reset_n = dfi_reset_n_i;
        cur.cs_n    = dfi_cs_n_i;
        cur.ras_n   = dfi_ras_n_i;
        cur.cas_n   = dfi_cas_n_i;
        cur.we_n    = dfi_we_n_i;
        cur.odt     = dfi_odt_i;
        cur.ba      = dfi_bank_i;
        cur.addr    = dfi_address_i;
        cmd_h[k]    = cur;
        wrdata_h[k] = dfi_wrdata_i;
        wrmask_h[k] = dfi_wrdata_mask_i;
        wr_en_h[k]  = dfi_wrdata_en_i;
        rd_en_h[k]  = dfi_rddata_en_i;
        rise_h[k]   = dq_rise_i;
        fall_h[k]   = dq_fall_i;
        lat_h[k]    = model_lat;
        // New latency applies from the next cycle on
        if (cfg_valid_i)
        begin
            model_lat = cfg_i[`PHY_CFG_RDLAT_LSB +: RD_LAT_W];
        end
    endtask

    task automatic check_cycle(int k);
        logic [DFI_DATA_W-1:0] wr_exp;
        logic [DFI_MASK_W-1:0] dm_exp;
        wr_exp = delayed_wrdata(k);
        dm_exp = delayed_wrmask(k);
        check_command(delayed_cmd(k));
        check_dq_half("dq_rise_o", wr_exp[DQ_W-1:0], dq_rise_o);
        check_dq_half("dq_fall_o", wr_exp[DFI_DATA_W-1:DQ_W], dq_fall_o);
        check_dm_half("dm_rise_o", dm_exp[DM_W-1:0], dm_rise_o);
        check_dm_half("dm_fall_o", dm_exp[DFI_MASK_W-1:DM_W], dm_fall_o);
        check_bit("dq_oe_o", oe_from_history(k), dq_oe_o);
        check_word("dfi_rddata_o", rddata_from_halves(k), dfi_rddata_o);
        check_bit("dfi_rddata_valid_o", valid_from_history(k), dfi_rddata_valid_o);
    endtask

    // Falling edge, inputs and outputs both settled
    initial
    begin
        cyc       = 0;
        model_lat = rd_lat_t'(RESET_RD_LAT);
        forever
        begin
            @(negedge clk_i);
            cyc = cyc + 1;
            record_inputs(cyc);
            if (cyc > N_RESET)
            begin
                check_cycle(cyc);
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        stop_on_error("Watchdog expired before the stimulus finished");
    end

endmodule

`default_nettype wire

// File: ddr3_dfi_phy.f
+incdir+include
+incdir+test
hw/ddr3_pins_pkg.sv
hw/dfi_pkg.sv
hw/ddr3_cmd_out.sv
hw/ddr3_wr_path.sv
hw/ddr3_rd_path.sv
hw/ddr3_dfi_phy.sv
test/tb_ddr3_dfi_phy.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := ddr3_dfi_phy.f
TB_TOP     := tb_ddr3_dfi_phy
RTL_TOP    := ddr3_dfi_phy
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

# Lint the design from its own top level
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run, exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
